/* axi_rd_if.sv */
// ====================
// AXI-Lite read channels
// address and data channel of one read port
// ====================
`default_nettype none
`include "fetch_settings.svh"

interface axi_rd_if;
	import fetch_pkg::*;

	// read address channel
	logic [`FETCH_ADDR_W-1:0] araddr;
	logic                     arvalid;
	logic                     arready;

	// read data channel
	logic [31:0] rdata;
	axi_resp_t   rresp;
	logic        rvalid;
	logic        rready;

	modport master (
		output araddr, arvalid, rready,
		input  arready, rdata, rresp, rvalid
	);

	modport slave (
		input  araddr, arvalid, rready,
		output arready, rdata, rresp, rvalid
	);

endinterface

`default_nettype wire

/* fetch_csr.sv */
// ====================
// fetch control block
// Wishbone classic slave with fetch enable,
// reset and trap vectors and fault status
// ====================
`default_nettype none
`include "fetch_settings.svh"

module fetch_csr (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [2:0]               wb_adr,
	input  logic [31:0]              wb_dat_w,
	output logic [31:0]              wb_dat_r,
	output logic                     wb_ack,
	input  logic                     fault_pulse,
	input  logic [`FETCH_ADDR_W-1:0] fault_pc,
	output logic                     fetch_en,
	output logic [`FETCH_ADDR_W-1:0] reset_vec,
	output logic [`FETCH_ADDR_W-1:0] trap_vec
);
	import fetch_pkg::*;

	csr_index_t               idx;
	logic                     req;
	logic                     wr;
	logic [31:0]              rd_data;
	logic [`FETCH_ADDR_W-1:0] fault_addr;
	logic [31:0]              fault_cnt;
	// boot address, loaded into the pc by the next reset
	logic [`FETCH_ADDR_W-1:0] boot_vec = `FETCH_RESET_VECTOR;

	assign idx = csr_index_t'(wb_adr);
	// one access per strobe, ack drops the cycle after
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign wr = req && wb_we;
	assign reset_vec = boot_vec;

	always_comb begin
		case (idx)
			`CSR_CTRL:       rd_data = {31'b0, fetch_en};
			`CSR_RESET_VEC:  rd_data = boot_vec;
			`CSR_TRAP_VEC:   rd_data = trap_vec;
			`CSR_FAULT_ADDR: rd_data = fault_addr;
			`CSR_FAULT_CNT:  rd_data = fault_cnt;
			default:         rd_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack     <= 1'b0;
			fetch_en   <= 1'b0;
			trap_vec   <= '0;
			fault_addr <= '0;
			fault_cnt  <= '0;
		end else begin
			wb_ack <= req;
			if (fault_pulse) begin
				fault_addr <= fault_pc;
				// counter sticks at all ones
				if (fault_cnt != '1)
					fault_cnt <= fault_cnt + 1'b1;
			end
			// a write to the counter wins over a fault in the same cycle
			if (wr) begin
				case (idx)
					`CSR_CTRL:      fetch_en <= wb_dat_w[0];
					`CSR_TRAP_VEC:  trap_vec <= {wb_dat_w[`FETCH_ADDR_W-1:2], 2'b00};
					`CSR_FAULT_CNT: fault_cnt <= '0;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr && idx == `CSR_RESET_VEC)
			boot_vec <= {wb_dat_w[`FETCH_ADDR_W-1:2], 2'b00};
	end

	// read data lines up with ack
	always_ff @(posedge clk) begin
		if (req)
			wb_dat_r <= rd_data;
	end

	// ack answers a strobe that is still held, once
	ack_single_a: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> wb_cyc && wb_stb && !$past(wb_ack))
		else $error("wishbone ack repeated or outside a request");

endmodule

`default_nettype wire

/* fetch_pkg.sv */
// ====================
// fetch package
// state, response and register index types
// shared by the fetch front end
// ====================
`default_nettype none

package fetch_pkg;

	// fetch sequence, one instruction in flight
	typedef enum logic [2:0] {
		IDLE,
		ADDR,
		DATA,
		HOLD,
		UPDATE,
		SETTLE
	} fetch_state_t;

	// AXI read response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

	// word index into the control block
	typedef logic [2:0] csr_index_t;

endpackage

`default_nettype wire

/* fetch_settings.svh */
// ====================
// fetch front end settings
// widths, settle time, boot address and
// Wishbone register offsets
// ====================
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// instruction address width
`define FETCH_ADDR_W 32

// idle cycles after a pc write before the next fetch
`define FETCH_SETTLE_CYCLES 2

// boot address loaded at the first reset
`define FETCH_RESET_VECTOR 32'h8000_0000

// control block word offsets
`define CSR_CTRL       3'd0
`define CSR_RESET_VEC  3'd1
`define CSR_TRAP_VEC   3'd2
`define CSR_FAULT_ADDR 3'd3
`define CSR_FAULT_CNT  3'd4

`endif

/* fetch_top.sv */
// ====================
// fetch front end top
// control block, fetch unit and pc register
// with flat AXI-Lite and Wishbone ports
// ====================
`default_nettype none
`include "fetch_settings.svh"

module fetch_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [`FETCH_ADDR_W-1:0] npc,
	input  logic                     id_ready,
	output logic                     if_valid,
	output logic [31:0]              inst,
	output logic [`FETCH_ADDR_W-1:0] pc,
	output logic [`FETCH_ADDR_W-1:0] axi_araddr,
	output logic                     axi_arvalid,
	input  logic                     axi_arready,
	input  logic [31:0]              axi_rdata,
	input  fetch_pkg::axi_resp_t     axi_rresp,
	input  logic                     axi_rvalid,
	output logic                     axi_rready,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [2:0]               wb_adr,
	input  logic [31:0]              wb_dat_w,
	output logic [31:0]              wb_dat_r,
	output logic                     wb_ack
);

	logic                     fetch_en;
	logic [`FETCH_ADDR_W-1:0] reset_vec;
	logic [`FETCH_ADDR_W-1:0] trap_vec;
	logic                     pc_w;
	logic                     fault_pulse;

	axi_rd_if axi ();

	// flatten the read port
	assign axi_araddr  = axi.araddr;
	assign axi_arvalid = axi.arvalid;
	assign axi_rready  = axi.rready;
	assign axi.arready = axi_arready;
	assign axi.rdata   = axi_rdata;
	assign axi.rresp   = axi_rresp;
	assign axi.rvalid  = axi_rvalid;

	fetch_csr i_fetch_csr (
		.clk         (clk),
		.reset       (reset),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.fault_pulse (fault_pulse),
		.fault_pc    (pc),
		.fetch_en    (fetch_en),
		.reset_vec   (reset_vec),
		.trap_vec    (trap_vec)
	);

	ifu i_ifu (
		.clk         (clk),
		.reset       (reset),
		.fetch_en    (fetch_en),
		.pc          (pc),
		.id_ready    (id_ready),
		.axi         (axi.master),
		.if_valid    (if_valid),
		.inst        (inst),
		.pc_w        (pc_w),
		.fault_pulse (fault_pulse)
	);

	// a fault loads the trap vector
	pc_reg i_pc_reg (
		.clk       (clk),
		.reset     (reset),
		.pc_w      (pc_w),
		.fault_w   (fault_pulse),
		.npc       (npc),
		.reset_vec (reset_vec),
		.trap_vec  (trap_vec),
		.pc        (pc)
	);

endmodule

`default_nettype wire

/* ifu.sv */
// ====================
// instruction fetch unit
// reads one word over AXI-Lite, hands it to
// decode and steps the pc after acceptance
// ====================
`default_nettype none
`include "fetch_settings.svh"

module ifu (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     fetch_en,
	input  logic [`FETCH_ADDR_W-1:0] pc,
	input  logic                     id_ready,
	axi_rd_if.master                 axi,
	output logic                     if_valid,
	output logic [31:0]              inst,
	output logic                     pc_w,
	output logic                     fault_pulse
);
	import fetch_pkg::*;

	localparam int SETTLE_CYC = `FETCH_SETTLE_CYCLES;
	localparam int CNT_W = $clog2(SETTLE_CYC + 2);

	fetch_state_t     state;
	logic [CNT_W-1:0] settle_cnt;
	axi_resp_t        rresp_q;
	logic             resp_err;
	logic             r_xfer;

	assign r_xfer = axi.rvalid && axi.rready;
	// slave or decode error means access fault
	assign resp_err = (rresp_q == SLVERR) || (rresp_q == DECERR);

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= IDLE;
			if_valid    <= 1'b0;
			pc_w        <= 1'b0;
			fault_pulse <= 1'b0;
			axi.arvalid <= 1'b0;
			axi.rready  <= 1'b0;
			settle_cnt  <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (fetch_en) begin
						axi.arvalid <= 1'b1;
						state       <= ADDR;
					end
				end
				ADDR: begin
					// address accepted, wait for data
					if (axi.arready) begin
						axi.arvalid <= 1'b0;
						axi.rready  <= 1'b1;
						state       <= DATA;
					end
				end
				DATA: begin
					if (r_xfer) begin
						axi.rready <= 1'b0;
						state      <= HOLD;
					end
				end
				HOLD: begin
					if (!if_valid) begin
						if (resp_err) begin
							fault_pulse <= 1'b1;
							state       <= UPDATE;
						end else begin
							if_valid <= 1'b1;
						end
					end else if (id_ready) begin
						// decode took it, move the pc on
						if_valid <= 1'b0;
						pc_w     <= 1'b1;
						state    <= UPDATE;
					end
				end
				UPDATE: begin
					pc_w        <= 1'b0;
					fault_pulse <= 1'b0;
					if (SETTLE_CYC == 0) begin
						state <= IDLE;
					end else begin
						settle_cnt <= CNT_W'(SETTLE_CYC - 1);
						state      <= SETTLE;
					end
				end
				SETTLE: begin
					if (settle_cnt == '0)
						state <= IDLE;
					else
						settle_cnt <= settle_cnt - 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// address and returned word
	always_ff @(posedge clk) begin
		if (state == IDLE && fetch_en)
			axi.araddr <= pc;
		if (state == DATA && r_xfer) begin
			inst    <= axi.rdata;
			rresp_q <= axi.rresp;
		end
	end

	inst_hold_a: assert property (@(posedge clk) disable iff (reset)
		if_valid && !id_ready |=> if_valid && $stable(inst))
		else $error("instruction dropped or changed while stalled");

endmodule

`default_nettype wire

/* pc_reg.sv */
// ====================
// program counter
// boots from the reset vector, then takes
// the next address or the trap vector
// ====================
`default_nettype none
`include "fetch_settings.svh"

module pc_reg (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     pc_w,
	input  logic                     fault_w,
	input  logic [`FETCH_ADDR_W-1:0] npc,
	input  logic [`FETCH_ADDR_W-1:0] reset_vec,
	input  logic [`FETCH_ADDR_W-1:0] trap_vec,
	output logic [`FETCH_ADDR_W-1:0] pc
);

	always_ff @(posedge clk) begin
		if (reset)
			pc <= reset_vec;
		else if (fault_w)
			pc <= trap_vec;
		else if (pc_w)
			pc <= npc;
	end

	// ifu sends either an update or a fault, never both
	pc_excl_a: assert property (@(posedge clk) disable iff (reset)
		!(pc_w && fault_w))
		else $error("pc_w and fault_w together");

	// the control block keeps the trap vector aligned
	trap_align_a: assert property (@(posedge clk) disable iff (reset)
		fault_w |=> pc[1:0] == 2'b00)
		else $error("trap target not word aligned");

endmodule

`default_nettype wire

/* project.f */
+incdir+.
fetch_pkg.sv
axi_rd_if.sv
fetch_csr.sv
pc_reg.sv
ifu.sv
fetch_top.sv
tb_fetch.sv

/* run.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator
verilator --binary --timing --assert -f project.f --top-module tb_fetch -o tb_fetch_sim \
	&& ./obj_dir/tb_fetch_sim | tee /dev/stderr | grep "TESTS PASSED" > /dev/null \
	&& echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }

/* tb_fetch.sv */
// ====================
// fetch front end testbench
// AXI-Lite memory model with stalls and a fault window,
// decode side, Wishbone driver and fetch checker
// ====================
`default_nettype none
`include "fetch_settings.svh"

module tb_fetch;
	timeunit 1ns;
	timeprecision 1ps;
	import fetch_pkg::*;

	localparam logic [31:0] FAULT_BASE = 32'h9000_0000;
	localparam logic [31:0] TRAP_VEC_A = 32'h8000_0800;
	localparam logic [31:0] TRAP_VEC_B = 32'h8000_0c00;
	localparam logic [31:0] BOOT_VEC_B = 32'h8000_0400;
	localparam int FETCH_RUN = 40;
	localparam int WORST_FETCH_CYCLES = 60;
	localparam int TIMEOUT_NS = (2 * FETCH_RUN * WORST_FETCH_CYCLES + 800) * 20;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic [31:0] npc = '0;
	logic        id_ready = 1'b0;
	logic        if_valid;
	logic [31:0] inst;
	logic [31:0] pc;
	logic [31:0] axi_araddr;
	logic        axi_arvalid;
	logic        axi_arready = 1'b0;
	logic [31:0] axi_rdata = '0;
	axi_resp_t   axi_rresp = OKAY;
	logic        axi_rvalid = 1'b0;
	logic        axi_rready;
	logic        wb_cyc = 1'b0;
	logic        wb_stb = 1'b0;
	logic        wb_we = 1'b0;
	logic [2:0]  wb_adr = '0;
	logic [31:0] wb_dat_w = '0;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	// memory and decode side state
	integer      seed = 32'h7bd8_32c1;
	logic        env_rst;
	logic        ar_seen;
	logic        r_seen;
	logic [31:0] ar_addr;
	logic        rd_pending = 1'b0;
	logic [31:0] rd_addr = '0;
	int          rd_wait = 0;
	logic [31:0] rnd;

	// model of the front end
	logic [31:0] boot_m = `FETCH_RESET_VECTOR;
	logic [31:0] trap_m = '0;
	logic [31:0] model_pc = `FETCH_RESET_VECTOR;
	logic [31:0] fault_cnt_m = '0;
	logic [31:0] fault_addr_m = '0;
	logic [31:0] held_inst = '0;
	logic        held = 1'b0;
	logic        busy = 1'b0;
	logic        faulted = 1'b0;
	int          accepted = 0;
	int          faults_total = 0;

	always #10 clk = ~clk;

	fetch_top i_fetch_top (
		.clk         (clk),
		.reset       (reset),
		.npc         (npc),
		.id_ready    (id_ready),
		.if_valid    (if_valid),
		.inst        (inst),
		.pc          (pc),
		.axi_araddr  (axi_araddr),
		.axi_arvalid (axi_arvalid),
		.axi_arready (axi_arready),
		.axi_rdata   (axi_rdata),
		.axi_rresp   (axi_rresp),
		.axi_rvalid  (axi_rvalid),
		.axi_rready  (axi_rready),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack)
	);

	// program word at each address, halves swapped and scrambled
	function automatic logic [31:0] expected_inst(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h1357_9bdf;
	endfunction

	function automatic logic in_fault_window(input logic [31:0] addr);
		return addr[31:8] == FAULT_BASE[31:8];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// one Wishbone classic cycle, ends after ack
	task automatic wb_cycle(input logic we, input logic [2:0] adr, input logic [31:0] dat,
		output logic [31:0] rdat);
		@(posedge clk);
		#2;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		do @(negedge clk); while (!wb_ack);
		rdat = wb_dat_r;
		@(posedge clk);
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
		logic [31:0] unused_rd;
		wb_cycle(1'b1, adr, dat, unused_rd);
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] rdat);
		wb_cycle(1'b0, adr, '0, rdat);
	endtask

	task automatic wait_accepted(input int n);
		int target;
		target = accepted + n;
		while (accepted < target)
			@(posedge clk);
	endtask

	// disable fetch and let the last fetch run out
	task automatic stop_fetch();
		wb_write(`CSR_CTRL, 32'd0);
		@(negedge clk);
		while (busy || axi_arvalid)
			@(negedge clk);
		repeat (`FETCH_SETTLE_CYCLES + 4) @(posedge clk);
	endtask

	// AXI-Lite memory and decode, sampled before the edge and driven after it
	always begin
		@(negedge clk);
		env_rst = reset;
		ar_seen = axi_arvalid && axi_arready;
		r_seen = axi_rvalid && axi_rready;
		ar_addr = axi_araddr;
		@(posedge clk);
		#2;
		if (env_rst) begin
			rd_pending = 1'b0;
			axi_rvalid = 1'b0;
			axi_arready = 1'b0;
			id_ready = 1'b0;
		end else begin
			rnd = $random(seed);
			id_ready = rnd[1:0] != 2'b00;
			if (r_seen) begin
				axi_rvalid = 1'b0;
				rd_pending = 1'b0;
			end
			if (ar_seen) begin
				rd_pending = 1'b1;
				rd_addr = ar_addr;
				rd_wait = int'(rnd[3:2]);
				// next address for this instruction, 1 in 8 into the fault window
				if (rnd[31:29] == 3'd0)
					npc = {FAULT_BASE[31:8], rnd[9:4], 2'b00};
				else if (rnd[31:29] < 3'd3)
					npc = {20'h8000_0, rnd[19:10], 2'b00};
				else
					npc = ar_addr + 32'd4;
			end
			axi_arready = !rd_pending && rnd[5:4] != 2'b00;
			if (rd_pending && !axi_rvalid) begin
				if (rd_wait == 0) begin
					axi_rvalid = 1'b1;
					if (in_fault_window(rd_addr)) begin
						axi_rresp = SLVERR;
						axi_rdata = '0;
					end else begin
						axi_rresp = OKAY;
						axi_rdata = expected_inst(rd_addr);
					end
				end else begin
					rd_wait = rd_wait - 1;
				end
			end
		end
	end

	// compare process, follows every transfer against the model pc
	always @(negedge clk) begin
		if (reset) begin
			held = 1'b0;
			busy = 1'b0;
			faulted = 1'b0;
			model_pc = boot_m;
			fault_cnt_m = '0;
			fault_addr_m = '0;
		end else begin
			if (held) begin
				check_value("if_valid", 32'(if_valid), 32'd1);
				check_value("inst", inst, held_inst);
			end
			held = if_valid && !id_ready;
			held_inst = inst;
			if (axi_arvalid && axi_arready) begin
				check_value("axi_araddr", axi_araddr, model_pc);
				busy = 1'b1;
				faulted = 1'b0;
			end
			if (axi_rvalid && axi_rready && axi_rresp == SLVERR) begin
				fault_addr_m = model_pc;
				fault_cnt_m = fault_cnt_m + 32'd1;
				faults_total = faults_total + 1;
				model_pc = trap_m;
				faulted = 1'b1;
				busy = 1'b0;
			end
			if (faulted && if_valid)
				check_value("if_valid", 32'(if_valid), 32'd0);
			if (if_valid && id_ready) begin
				check_value("pc", pc, model_pc);
				check_value("inst", inst, expected_inst(model_pc));
				model_pc = npc;
				accepted = accepted + 1;
				busy = 1'b0;
			end
			// a write to the fault counter clears it
			if (wb_ack && wb_we && wb_adr == `CSR_FAULT_CNT)
				fault_cnt_m = '0;
		end
	end

	initial begin : main_seq
		logic [31:0] rd;
		logic [31:0] pc_before;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		// fetch stays off until enabled
		repeat (8) begin
			@(negedge clk);
			check_value("axi_arvalid", 32'(axi_arvalid), 32'd0);
			check_value("axi_rready", 32'(axi_rready), 32'd0);
			check_value("if_valid", 32'(if_valid), 32'd0);
			check_value("pc", pc, `FETCH_RESET_VECTOR);
		end
		wb_read(`CSR_CTRL, rd);
		check_value("ctrl", rd, 32'd0);
		wb_read(`CSR_RESET_VEC, rd);
		check_value("reset_vec", rd, `FETCH_RESET_VECTOR);
		wb_write(`CSR_TRAP_VEC, TRAP_VEC_A);
		trap_m = TRAP_VEC_A;
		wb_read(`CSR_TRAP_VEC, rd);
		check_value("trap_vec", rd, TRAP_VEC_A);
		wb_write(`CSR_CTRL, 32'd1);
		wb_read(`CSR_CTRL, rd);
		check_value("ctrl", rd, 32'd1);
		wait_accepted(FETCH_RUN);
		stop_fetch();

		// fault status, then clear the counter
		wb_read(`CSR_FAULT_CNT, rd);
		check_value("fault_cnt", rd, fault_cnt_m);
		wb_read(`CSR_FAULT_ADDR, rd);
		check_value("fault_addr", rd, fault_addr_m);
		wb_write(`CSR_FAULT_CNT, 32'd0);
		wb_read(`CSR_FAULT_CNT, rd);
		check_value("fault_cnt", rd, 32'd0);

		// new boot address waits for the next reset
		pc_before = pc;
		wb_write(`CSR_RESET_VEC, BOOT_VEC_B);
		boot_m = BOOT_VEC_B;
		wb_read(`CSR_RESET_VEC, rd);
		check_value("reset_vec", rd, BOOT_VEC_B);
		check_value("pc", pc, pc_before);
		@(posedge clk);
		#2;
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		check_value("pc", pc, BOOT_VEC_B);
		wb_write(`CSR_TRAP_VEC, TRAP_VEC_B);
		trap_m = TRAP_VEC_B;
		wb_write(`CSR_CTRL, 32'd1);
		wait_accepted(FETCH_RUN);
		stop_fetch();
		wb_read(`CSR_FAULT_CNT, rd);
		check_value("fault_cnt", rd, fault_cnt_m);
		wb_read(`CSR_FAULT_ADDR, rd);
		check_value("fault_addr", rd, fault_addr_m);

		if (faults_total == 0) begin
			$display("No access fault was hit by the random jumps");
			$display("TESTS FAILED");
			$fatal(1, "fault path not covered");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

	// watchdog sized from the fetch count
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the fetch front end stopped delivering instructions");
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
